// File: Bender.yml
package:
  name: l2_emulator

export_include_dirs:
  - include

sources:
  - files:
      - verilog/l2_geom_pkg.sv
      - verilog/l2_bus_pkg.sv
      - verilog/l2_word_store.sv
      - verilog/l2_read_port.sv
      - verilog/l2_write_port.sv
      - verilog/l2_emulator_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_l2_emulator.sv

// File: l2_emulator_top.f
+incdir+include
verilog/l2_geom_pkg.sv
verilog/l2_bus_pkg.sv
verilog/l2_word_store.sv
verilog/l2_read_port.sv
verilog/l2_write_port.sv
verilog/l2_emulator_top.sv
sim/tb_l2_emulator.sv

// File: include/l2_tb_tasks.svh
`ifndef L2_TB_TASKS_SVH
`define L2_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Port selection, 0 is the instruction port and 1 the data port
//////////////////////////////////////////////////////////////////////

function automatic logic beat_ready_of(input int p);
    return (p == 0) ? ins_beat_ready : dat_beat_ready;
endfunction

function automatic logic req_ready_of(input int p);
    return (p == 0) ? ins_req_ready : dat_req_ready;
endfunction

function automatic l2_rd_req_t req_of(input int p);
    return (p == 0) ? ins_req : dat_req;
endfunction

task automatic drive_req(input int p, input logic v, input int addr);
    l2_rd_req_t r;
    r.valid     = v;
    r.addr.word = ADDR_WIDTH'(addr);
    if (p == 0) begin
        ins_req = r;
    end else begin
        dat_req = r;
    end
endtask

task automatic set_beat_ready(input int p, input logic v);
    if (p == 0) begin
        ins_beat_ready = v;
    end else begin
        dat_beat_ready = v;
    end
endtask

function automatic l2_beat_t random_beat();
    l2_beat_t b;
    for (int i = 0; i < LANES; i++) begin
        b[i] = $random(seed);
    end
    return b;
endfunction

// Beat k of a burst, starting at the beat of the requested word and wrapping
function automatic l2_beat_t expected_beat(input int addr, input int k);
    l2_beat_t b;
    int       blk_base;
    int       first;
    int       idx;
    int       a;
    blk_base = addr - (addr % (LANES * L2_BURST));
    first    = (addr / LANES) % L2_BURST;
    idx      = (first + k) % L2_BURST;
    for (int lane = 0; lane < LANES; lane++) begin
        a       = blk_base + idx * LANES + lane;
        b[lane] = ref_mem.exists(a) ? ref_mem[a] : 'x;
    end
    return b;
endfunction

// Called on a falling edge, returns on the falling edge after the beat is taken
task automatic send_write_beat(input int base);
    int waited;
    waited   = 0;
    wr.valid = 1'b1;
    wr.addr.word = ADDR_WIDTH'(base);
    wr.data  = random_beat();
    #1;
    while (!wr_ready && waited < HS_LIMIT) begin
        @(negedge CLK);
        #1;
        waited++;
    end
    if (!wr_ready) begin
        $display("write port never raised wr_ready for a beat");
        errors++;
    end
    @(negedge CLK);
    wr.valid = 1'b0;
endtask

task automatic wait_write_done();
    int waited;
    waited = 0;
    while (!wr_complete && waited < HS_LIMIT) begin
        @(negedge CLK);
        #1;
        waited++;
    end
    if (!wr_complete) begin
        $display("write burst never signalled wr_complete");
        errors++;
    end
    @(negedge CLK);
endtask

`endif

// File: sim/tb_l2_emulator.sv
`timescale 1ns/1ps

module tb_l2_emulator
    import l2_geom_pkg::*;
    import l2_bus_pkg::*;
();

    localparam int RD_DELAY        = 7;
    localparam int WR_DELAY        = 4;
    localparam int CLK_PERIOD      = 40;
    localparam int HS_LIMIT        = 50;
    localparam int KEY_STRIDE      = 1000000;
    localparam int WATCHDOG_CYCLES = 10 + 6 * (RD_DELAY + WR_DELAY + 3 * L2_BURST + 10) + 200;

    logic         CLK;
    logic         arst_n;
    l2_rd_req_t   ins_req;
    logic         ins_req_ready;
    l2_beat_out_t ins_beat;
    logic         ins_beat_ready;
    l2_rd_req_t   dat_req;
    logic         dat_req_ready;
    l2_beat_out_t dat_beat;
    logic         dat_beat_ready;
    l2_wr_beat_t  wr;
    logic         wr_ready;
    logic         wr_complete;

    int       seed = 71;
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       test_err_start;

    // Reference model state
    int       cyc;
    int       port_cnt [2];
    int       busy_until [2];
    int       last_accept [2];
    int       pending_until [2];
    int       wr_beat_idx;
    int       wr_last_cyc;
    l2_word_t ref_mem [int];
    l2_beat_t exp_beats [int];
    logic     exp_ready [2];
    logic     exp_valid [2];
    l2_beat_t exp_data [2];
    logic     exp_wr_ready;
    logic     exp_wr_complete;

    `include "l2_tb_tasks.svh"

    l2_emulator_top dut (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .ins_req        (ins_req),
        .ins_req_ready  (ins_req_ready),
        .ins_beat       (ins_beat),
        .ins_beat_ready (ins_beat_ready),
        .dat_req        (dat_req),
        .dat_req_ready  (dat_req_ready),
        .dat_beat       (dat_beat),
        .dat_beat_ready (dat_beat_ready),
        .wr             (wr),
        .wr_ready       (wr_ready),
        .wr_complete    (wr_complete)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model advanced on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge CLK) begin : model_step
        l2_rd_req_t r;
        if (arst_n) begin
            cyc++;
            for (int p = 0; p < 2; p++) begin
                r = req_of(p);
                // Port time only moves while the consumer takes beats
                if (beat_ready_of(p)) begin
                    port_cnt[p]++;
                    if (r.valid && exp_ready[p]) begin
                        last_accept[p]   = port_cnt[p];
                        busy_until[p]    = port_cnt[p] + L2_BURST - 1;
                        pending_until[p] = port_cnt[p] + RD_DELAY + L2_BURST - 1;
                        for (int k = 0; k < L2_BURST; k++) begin
                            exp_beats[p * KEY_STRIDE + port_cnt[p] + RD_DELAY + k] =
                                expected_beat(int'(r.addr.word), k);
                        end
                    end
                end
            end
            if (wr.valid && exp_wr_ready) begin
                for (int lane = 0; lane < LANES; lane++) begin
                    ref_mem[int'(wr.addr.word) + wr_beat_idx * LANES + lane] = wr.data[lane];
                end
                if (wr_beat_idx == L2_BURST - 1) begin
                    wr_last_cyc = cyc;
                    wr_beat_idx = 0;
                end else begin
                    wr_beat_idx++;
                end
            end
        end
    end

    // Expected outputs settle after the falling-edge drive
    always @(negedge CLK) begin
        #2;
        for (int p = 0; p < 2; p++) begin
            exp_ready[p] = beat_ready_of(p) && (port_cnt[p] >= busy_until[p]);
            exp_valid[p] = exp_beats.exists(p * KEY_STRIDE + port_cnt[p]);
            exp_data[p]  = exp_valid[p] ? exp_beats[p * KEY_STRIDE + port_cnt[p]] : '0;
        end
        exp_wr_ready    = !(cyc >= wr_last_cyc && cyc <= wr_last_cyc + WR_DELAY);
        exp_wr_complete = (cyc == wr_last_cyc + WR_DELAY);
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("error: %0d ns: %s", $time, msg);
        errors++;
    endtask

    ins_ready_a : assert property (@(posedge CLK) disable iff (!arst_n)
        ins_req_ready == exp_ready[0])
        else report_mismatch("ins_req_ready differs from model");

    dat_ready_a : assert property (@(posedge CLK) disable iff (!arst_n)
        dat_req_ready == exp_ready[1])
        else report_mismatch("dat_req_ready differs from model");

    ins_beat_a : assert property (@(posedge CLK) disable iff (!arst_n)
        ins_beat.valid == exp_valid[0] && (!exp_valid[0] || ins_beat.data == exp_data[0]))
        else report_mismatch("ins_beat valid or data wrong");

    dat_beat_a : assert property (@(posedge CLK) disable iff (!arst_n)
        dat_beat.valid == exp_valid[1] && (!exp_valid[1] || dat_beat.data == exp_data[1]))
        else report_mismatch("dat_beat valid or data wrong");

    wr_ready_a : assert property (@(posedge CLK) disable iff (!arst_n)
        wr_ready == exp_wr_ready)
        else report_mismatch("wr_ready differs from model");

    wr_complete_a : assert property (@(posedge CLK) disable iff (!arst_n)
        wr_complete == exp_wr_complete)
        else report_mismatch("wr_complete differs from model");

    //////////////////////////////////////////////////////////////////////
    // Read stimulus
    //////////////////////////////////////////////////////////////////////

    // Runs from one falling edge to the falling edge after acceptance
    task automatic issue_read(input int p, input int addr);
        int waited;
        waited = 0;
        drive_req(p, 1'b1, addr);
        #1;
        while (!req_ready_of(p) && waited < HS_LIMIT) begin
            @(negedge CLK);
            #1;
            waited++;
        end
        if (!req_ready_of(p)) begin
            $display("read port %0d never raised req_ready", p);
            errors++;
        end
        @(negedge CLK);
        drive_req(p, 1'b0, 0);
    endtask

    // Lets all beats out and may stall the consumer after beat 1
    task automatic drain_read(input int p, input int stall_len);
        int waited;
        waited = 0;
        while (port_cnt[p] <= pending_until[p] && waited < HS_LIMIT) begin
            if (stall_len > 0 && port_cnt[p] == last_accept[p] + RD_DELAY + 1) begin
                set_beat_ready(p, 1'b0);
                repeat (stall_len) @(negedge CLK);
                set_beat_ready(p, 1'b1);
                stall_len = 0;
            end
            @(negedge CLK);
            waited++;
        end
        if (port_cnt[p] <= pending_until[p]) begin
            $display("read burst on port %0d did not finish in time", p);
            errors++;
        end
        repeat (2) @(negedge CLK);
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", num, name);
        end
        test_err_start = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int base;
        base           = 64;
        arst_n         = 1'b0;
        ins_req        = '0;
        dat_req        = '0;
        ins_beat_ready = 1'b1;
        dat_beat_ready = 1'b1;
        wr             = '0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        cyc            = 0;
        wr_beat_idx    = 0;
        wr_last_cyc    = -100;
        for (int p = 0; p < 2; p++) begin
            port_cnt[p]      = 0;
            busy_until[p]    = 0;
            last_accept[p]   = -100;
            pending_until[p] = -1;
        end

        repeat (10) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        repeat (3) @(negedge CLK);
        finish_test(1, "reset levels");

        // Gap of two cycles before the third beat
        for (int k = 0; k < L2_BURST; k++) begin
            if (k == 2) begin
                repeat (2) @(negedge CLK);
            end
            send_write_beat(base);
        end
        wait_write_done();
        finish_test(2, "write burst");

        issue_read(1, base);
        drain_read(1, 0);
        finish_test(3, "data read beat 0");

        issue_read(1, base + 2 * LANES + 1);
        drain_read(1, 0);
        finish_test(4, "data read wrap from beat 2");

        issue_read(0, base + LANES);
        drain_read(0, 3);
        finish_test(5, "instruction read with stall");

        issue_read(1, base);
        issue_read(1, base + 3 * LANES);
        drain_read(1, 0);
        finish_test(6, "back to back data reads");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verilog/l2_bus_pkg.sv
package l2_bus_pkg;

    import l2_geom_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Port payloads between the caches and the L2 model
    //////////////////////////////////////////////////////////////////////

    // Read request, word address of the critical word
    typedef struct packed {
        logic     valid;
        l2_addr_u addr;
    } l2_rd_req_t;

    // One returned beat of a read burst
    typedef struct packed {
        logic     valid;
        l2_beat_t data;
    } l2_beat_out_t;

    // One write beat, addr is the base of the whole burst
    typedef struct packed {
        logic     valid;
        l2_addr_u addr;
        l2_beat_t data;
    } l2_wr_beat_t;

endpackage

// File: verilog/l2_emulator_top.sv
`timescale 1ns/1ps

module l2_emulator_top
    import l2_geom_pkg::*;
    import l2_bus_pkg::*;
#(
    parameter int RD_DELAY       = 7,
    parameter int WR_DELAY       = 4,
    parameter int MEM_ADDR_WIDTH = 12
) (
    input  logic         CLK,
    input  logic         arst_n,

    // Instruction read port
    input  l2_rd_req_t   ins_req,
    output logic         ins_req_ready,
    output l2_beat_out_t ins_beat,
    input  logic         ins_beat_ready,

    // Data read port
    input  l2_rd_req_t   dat_req,
    output logic         dat_req_ready,
    output l2_beat_out_t dat_beat,
    input  logic         dat_beat_ready,

    // Data write port
    input  l2_wr_beat_t  wr,
    output logic         wr_ready,
    output logic         wr_complete
);

    l2_addr_u ins_store_addr;
    l2_beat_t ins_store_beat;
    l2_addr_u dat_store_addr;
    l2_beat_t dat_store_beat;

    logic     store_wr_en;
    l2_addr_u store_wr_addr;
    l2_beat_t store_wr_data;

    // Single store shared by all three ports
    l2_word_store #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_store (
        .CLK       (CLK),
        .rd_addr_a (ins_store_addr),
        .rd_beat_a (ins_store_beat),
        .rd_addr_b (dat_store_addr),
        .rd_beat_b (dat_store_beat),
        .wr_en     (store_wr_en),
        .wr_addr   (store_wr_addr),
        .wr_data   (store_wr_data)
    );

    l2_read_port #(
        .RD_DELAY       (RD_DELAY),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_ins_port (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .req        (ins_req),
        .req_ready  (ins_req_ready),
        .beat       (ins_beat),
        .beat_ready (ins_beat_ready),
        .store_addr (ins_store_addr),
        .store_beat (ins_store_beat)
    );

    l2_read_port #(
        .RD_DELAY       (RD_DELAY),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_dat_port (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .req        (dat_req),
        .req_ready  (dat_req_ready),
        .beat       (dat_beat),
        .beat_ready (dat_beat_ready),
        .store_addr (dat_store_addr),
        .store_beat (dat_store_beat)
    );

    l2_write_port #(
        .WR_DELAY (WR_DELAY)
    ) u_wr_port (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .wr          (wr),
        .wr_ready    (wr_ready),
        .wr_complete (wr_complete),
        .store_wr_en (store_wr_en),
        .store_addr  (store_wr_addr),
        .store_data  (store_wr_data)
    );

endmodule

// File: verilog/l2_geom_pkg.sv
package l2_geom_pkg;

    //////////////////////////////////////////////////////////////////////
    // Word, beat and block geometry
    //////////////////////////////////////////////////////////////////////

    // One memory word
    localparam int WORD_WIDTH = 32;

    // Words per bus beat, 128-bit bus
    localparam int LANES      = 4;

    // Beats per cache block, 512-bit block
    localparam int L2_BURST   = 4;

    // Word address width
    localparam int ADDR_WIDTH = 30;

    localparam int LANE_BITS  = $clog2(LANES);
    localparam int BEAT_BITS  = $clog2(L2_BURST);
    localparam int BLOCK_BITS = ADDR_WIDTH - BEAT_BITS - LANE_BITS;

    typedef logic [WORD_WIDTH-1:0] l2_word_t;

    // Lane 0 sits in the low word of the beat
    typedef l2_word_t [LANES-1:0] l2_beat_t;

    // Word address split into block, beat within block and lane within beat
    typedef struct packed {
        logic [BLOCK_BITS-1:0] block;
        logic [BEAT_BITS-1:0]  beat;
        logic [LANE_BITS-1:0]  lane;
    } l2_addr_fields_t;

    // Flat view for the store, field view for burst alignment
    typedef union packed {
        logic [ADDR_WIDTH-1:0] word;
        l2_addr_fields_t       f;
    } l2_addr_u;

endpackage

// File: verilog/l2_read_port.sv
`timescale 1ns/1ps

module l2_read_port
    import l2_geom_pkg::*;
    import l2_bus_pkg::*;
#(
    parameter int RD_DELAY       = 7,
    parameter int MEM_ADDR_WIDTH = 12
) (
    input  logic         CLK,
    input  logic         arst_n,

    input  l2_rd_req_t   req,
    output logic         req_ready,

    output l2_beat_out_t beat,
    input  logic         beat_ready,

    output l2_addr_u     store_addr,
    input  l2_beat_t     store_beat
);

    // Stages ahead of the sequencer
    // The last delay cycle is spent in the beat register
    localparam int PIPE_LEN  = RD_DELAY - 1;
    localparam int BUSY_LEN  = L2_BURST - 1;
    localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

    if (RD_DELAY < 2) begin : g_delay_check
        $error("RD_DELAY must be at least 2");
    end

    logic                accept;
    logic [BUSY_LEN-1:0] busy;

    logic [PIPE_LEN-1:0] pipe_vld;
    l2_addr_u            pipe_addr [PIPE_LEN];
    l2_addr_u            head_addr;

    logic [L2_BURST-1:0] seq_state;
    l2_addr_u            seq_addr;

    logic                beat_vld;
    l2_beat_t            beat_data;

    //////////////////////////////////////////////////////////////////////
    // Request acceptance
    //////////////////////////////////////////////////////////////////////

    // A stalled consumer also blocks new requests
    assign req_ready = (busy == '0) && beat_ready;
    assign accept    = req.valid && req_ready;

    //////////////////////////////////////////////////////////////////////
    // Delay line and burst sequencer
    //////////////////////////////////////////////////////////////////////

    // Burst starts at the critical beat with the lane field cleared
    always_comb begin
        head_addr        = pipe_addr[PIPE_LEN-1];
        head_addr.f.lane = '0;
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= '0;
            pipe_vld  <= '0;
            seq_state <= '0;
            beat_vld  <= 1'b0;
        end else if (beat_ready) begin
            busy     <= accept ? BUSY_LEN'(1) : (busy << 1);
            pipe_vld <= (pipe_vld << 1) | PIPE_LEN'(accept);

            // One-hot walk over the beats of the block
            if (pipe_vld[PIPE_LEN-1]) begin
                seq_state <= L2_BURST'(1);
            end else begin
                seq_state <= seq_state << 1;
            end

            beat_vld <= |seq_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (beat_ready) begin
            pipe_addr[0] <= req.addr;
            for (int j = 1; j < PIPE_LEN; j++) begin
                pipe_addr[j] <= pipe_addr[j-1];
            end

            // Beat field wraps inside the block
            if (pipe_vld[PIPE_LEN-1]) begin
                seq_addr <= head_addr;
            end else if (|seq_state) begin
                seq_addr.f.beat <= seq_addr.f.beat + 1'b1;
            end

            if (|seq_state) begin
                beat_data <= store_beat;
            end
        end
    end

    assign store_addr = seq_addr;
    assign beat       = '{valid: beat_vld, data: beat_data};

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    beat_hold_a : assert property (
        @(posedge CLK) disable iff (!arst_n)
        !beat_ready |=> $stable(beat)
    ) else $error("beat changed while consumer stalled");

    // A new burst never starts before the running one reaches its last beat
    no_burst_overlap_a : assert property (
        @(posedge CLK) disable iff (!arst_n)
        pipe_vld[PIPE_LEN-1] |-> (seq_state[L2_BURST-2:0] == '0)
    ) else $error("request reached sequencer while a burst was still running");

    // Whole block of an accepted request lies in the store
    req_in_range_a : assert property (
        @(posedge CLK) disable iff (!arst_n)
        accept |-> (int'(req.addr.word) < MEM_DEPTH)
    ) else $error("read request at word %0h outside store", req.addr.word);

endmodule

// File: verilog/l2_word_store.sv
`timescale 1ns/1ps

module l2_word_store
    import l2_geom_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 12
) (
    input  logic     CLK,

    input  l2_addr_u rd_addr_a,
    output l2_beat_t rd_beat_a,
    input  l2_addr_u rd_addr_b,
    output l2_beat_t rd_beat_b,

    input  logic     wr_en,
    input  l2_addr_u wr_addr,
    input  l2_beat_t wr_data
);

    localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

    typedef logic [MEM_ADDR_WIDTH-1:0] mem_idx_t;

    l2_word_t mem [MEM_DEPTH];

    // Word index of one lane, upper address bits fall outside the store
    function automatic mem_idx_t lane_idx(l2_addr_u addr, int lane);
        return mem_idx_t'(addr.word) + mem_idx_t'(lane);
    endfunction

    // Both read ports see the array before this cycle's write
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rd_beat_a[i] = mem[lane_idx(rd_addr_a, i)];
            rd_beat_b[i] = mem[lane_idx(rd_addr_b, i)];
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                mem[lane_idx(wr_addr, i)] <= wr_data[i];
            end
        end
    end

    // Whole write beat must land inside the array, no index wrap
    wr_in_range_a : assert property (
        @(posedge CLK) wr_en |-> (int'(wr_addr.word) + LANES <= MEM_DEPTH)
    ) else $error("write beat at word %0h runs past store depth", wr_addr.word);

endmodule

// File: verilog/l2_write_port.sv
`timescale 1ns/1ps

module l2_write_port
    import l2_geom_pkg::*;
    import l2_bus_pkg::*;
#(
    parameter int WR_DELAY = 4
) (
    input  logic        CLK,
    input  logic        arst_n,

    input  l2_wr_beat_t wr,
    output logic        wr_ready,
    output logic        wr_complete,

    output logic        store_wr_en,
    output l2_addr_u    store_addr,
    output l2_beat_t    store_data
);

    logic                 accept;
    logic                 last_beat;
    logic [BEAT_BITS-1:0] beat_cnt;
    logic                 ready_q;
    logic [WR_DELAY-1:0]  dly;
    logic                 complete_q;

    assign accept    = wr.valid && ready_q;
    assign last_beat = accept && (beat_cnt == BEAT_BITS'(L2_BURST - 1));

    //////////////////////////////////////////////////////////////////////
    // Store write, no wrap inside the block
    //////////////////////////////////////////////////////////////////////

    assign store_wr_en     = accept;
    assign store_addr.word = wr.addr.word + ADDR_WIDTH'({beat_cnt, {LANE_BITS{1'b0}}});
    assign store_data      = wr.data;

    //////////////////////////////////////////////////////////////////////
    // Burst close and completion
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt   <= '0;
            ready_q    <= 1'b1;
            dly        <= '0;
            complete_q <= 1'b0;
        end else begin
            // Counter rolls back to zero on the last beat
            if (accept) begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            if (last_beat) begin
                ready_q <= 1'b0;
            end else if (complete_q) begin
                ready_q <= 1'b1;
            end

            // Completion lands WR_DELAY edges after the last beat
            dly        <= (dly << 1) | WR_DELAY'(last_beat);
            complete_q <= dly[WR_DELAY-1];
        end
    end

    assign wr_ready    = ready_q;
    assign wr_complete = complete_q;

    // Ready stays low through the pulse and comes back right after it
    complete_ready_a : assert property (
        @(posedge CLK) disable iff (!arst_n)
        wr_complete |-> !wr_ready ##1 wr_ready
    ) else $error("wr_ready out of step with wr_complete");

endmodule
